// ==== rlbp_input.txt ====
// period vd_rise vd_fall sw_rise sw_fall sh_rise sh_fall sample_time (hex)
// then pixel bits p0 to p8 and the expected code, bit k = pk (hex)
00A 001 004 002 006 005 009 003 1 0 1 1 0 0 1 0 1 14D
010 000 008 004 00C 00A 00F 00C 0 0 0 0 0 0 0 0 0 000
006 001 003 002 005 000 006 001 1 1 1 1 1 1 1 1 1 1FF
00C 003 009 005 007 008 00B 00B 1 0 1 0 1 0 1 0 1 155
014 002 012 006 00A 00E 013 007 0 1 0 1 0 1 0 1 0 0AA
002 000 001 001 002 000 002 001 0 0 1 1 1 0 0 0 1 11C
040 010 030 030 010 020 03F 03F 1 1 0 1 0 0 0 1 1 18B
007 006 007 000 000 003 00A 005 0 1 1 0 1 1 0 1 0 0B6

// ==== all.f ====
rlbp_pkg.sv
frame_timer.sv
rlbp_sequencer.sv
window_shift.sv
code_serializer.sv
rlbp_readout_top.sv
rlbp_assert.sv
tb_rlbp_readout.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --assert -Wno-fatal --top-module tb_rlbp_readout -f all.f -o sim_rlbp \
	&& ./obj_dir/sim_rlbp \
	|| { echo "Build or simulation failed"; exit 1; }

// ==== tb_rlbp_readout.sv ====
/*
 * Testbench for the RLBP readout controller, driven frame by frame
 * from rlbp_input.txt with checks on the counter, windows and serial code
 */
`timescale 1ns/1ps

module tb_rlbp_readout;

	localparam int NUM_FRAMES = 8;
	localparam int FIELDS = 18;
	localparam int PIX_FIELD = 8;
	localparam int CODE_FIELD = 17;

	logic             clk;
	logic             reset;
	logic             start_i;
	logic             pixel_i;
	rlbp_pkg::count_t period_i;
	rlbp_pkg::count_t vd_rise_i;
	rlbp_pkg::count_t vd_fall_i;
	rlbp_pkg::count_t sw_rise_i;
	rlbp_pkg::count_t sw_fall_i;
	rlbp_pkg::count_t sh_rise_i;
	rlbp_pkg::count_t sh_fall_i;
	rlbp_pkg::count_t sample_time_i;
	rlbp_pkg::count_t count_o;
	logic             vd_o;
	logic             sw_o;
	logic             sh_o;
	logic             rlbp_done_o;
	logic             serial_o;
	logic             serial_valid_o;

	// Eighteen words per frame, in the column order of the input file
	rlbp_pkg::count_t frame_mem [NUM_FRAMES*FIELDS];
	int               cycle_count;
	int               cycle_limit;
	rlbp_pkg::count_t prev_count;
	logic             prev_start;
	logic             armed;

	rlbp_readout_top rlbp_readout_top_inst (.*);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic in_window(input rlbp_pkg::count_t count,
		input rlbp_pkg::count_t rise, input rlbp_pkg::count_t fall);
		return (count >= rise) && (count < fall);
	endfunction

	// Counter and window decoding, checked mid-cycle
	always @(negedge clk) begin
		if (reset) begin
			armed = 1'b0;
		end else begin
			if (armed) begin
				if (!prev_start || prev_count == period_i - 12'd1) begin
					check_value("count_o", 32'(count_o), 32'd0);
				end else begin
					check_value("count_o", 32'(count_o), 32'(prev_count + 12'd1));
				end
			end
			check_value("vd_o", 32'(vd_o), 32'(in_window(count_o, vd_rise_i, vd_fall_i)));
			check_value("sw_o", 32'(sw_o), 32'(in_window(count_o, sw_rise_i, sw_fall_i)));
			check_value("sh_o", 32'(sh_o), 32'(in_window(count_o, sh_rise_i, sh_fall_i)));
			prev_count = count_o;
			prev_start = start_i;
			armed = 1'b1;
		end
	end

	// Run limit worked out from the frame periods
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the DUT did not finish all frames in %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic run_frame(input int frame);
		int              base;
		int              captured;
		rlbp_pkg::code_t pix_bits;
		rlbp_pkg::code_t expected;
		base = frame * FIELDS;
		expected = rlbp_pkg::code_t'(frame_mem[base+CODE_FIELD]);
		for (int k = 0; k < rlbp_pkg::CODE_BITS; k++) begin
			pix_bits[k] = frame_mem[base+PIX_FIELD+k][0];
		end
		// Bit k of the code is the k-th pixel sample
		check_value("expected code rule", 32'(pix_bits), 32'(expected));
		@(posedge clk);
		period_i <= frame_mem[base];
		vd_rise_i <= frame_mem[base+1];
		vd_fall_i <= frame_mem[base+2];
		sw_rise_i <= frame_mem[base+3];
		sw_fall_i <= frame_mem[base+4];
		sh_rise_i <= frame_mem[base+5];
		sh_fall_i <= frame_mem[base+6];
		sample_time_i <= frame_mem[base+7];
		pixel_i <= pix_bits[0];
		@(posedge clk);
		start_i <= 1'b1;
		captured = 0;
		// Next pixel goes out on each capture edge
		do begin
			@(posedge clk);
			if (count_o == sample_time_i && captured < rlbp_pkg::CODE_BITS) begin
				captured++;
				if (captured < rlbp_pkg::CODE_BITS) begin
					pixel_i <= pix_bits[captured];
				end
			end
		end while (!rlbp_done_o);
		check_value("samples before rlbp_done_o", 32'(captured), 32'(rlbp_pkg::CODE_BITS));
		do begin
			@(posedge clk);
		end while (!serial_valid_o);
		for (int k = 0; k < rlbp_pkg::CODE_BITS; k++) begin
			if (k > 0) begin
				@(posedge clk);
			end
			check_value("serial_valid_o", 32'(serial_valid_o), 32'd1);
			check_value("rlbp_done_o", 32'(rlbp_done_o), 32'd1);
			check_value("serial_o", 32'(serial_o), 32'(expected[k]));
		end
		@(posedge clk);
		check_value("serial_valid_o", 32'(serial_valid_o), 32'd0);
		check_value("serial_o", 32'(serial_o), 32'd0);
		// Done holds through the first cycle with start low
		start_i <= 1'b0;
		@(posedge clk);
		check_value("rlbp_done_o", 32'(rlbp_done_o), 32'd1);
		@(posedge clk);
		check_value("rlbp_done_o", 32'(rlbp_done_o), 32'd0);
		check_value("count_o", 32'(count_o), 32'd0);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start_i = 1'b0;
		pixel_i = 1'b0;
		period_i = '0;
		vd_rise_i = '0;
		vd_fall_i = '0;
		sw_rise_i = '0;
		sw_fall_i = '0;
		sh_rise_i = '0;
		sh_fall_i = '0;
		sample_time_i = '0;
		cycle_count = 0;
		$readmemh("rlbp_input.txt", frame_mem);
		cycle_limit = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			cycle_limit = cycle_limit + 10 * int'(frame_mem[f*FIELDS]) + 40;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value("count_o", 32'(count_o), 32'd0);
		check_value("rlbp_done_o", 32'(rlbp_done_o), 32'd0);
		check_value("serial_valid_o", 32'(serial_valid_o), 32'd0);
		check_value("serial_o", 32'(serial_o), 32'd0);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			run_frame(f);
		end
		if (rlbp_readout_top_inst.rlbp_assert_inst.fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("Concurrent assertions failed %0d times",
				rlbp_readout_top_inst.rlbp_assert_inst.fail_count);
			$display("TEST RESULT: FAIL");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// ==== rlbp_assert.sv ====
/*
 * Concurrent checks on the readout top level ports
 */
`timescale 1ns/1ps

module rlbp_assert (
	input logic              clk,
	input logic              reset,
	input logic              start_i,
	input rlbp_pkg::count_t  count_i,
	input rlbp_pkg::count_t  period_i,
	input logic              rlbp_done_i,
	input logic              serial_valid_i
);

	int unsigned      fail_count = 0;
	rlbp_pkg::count_t valid_run;

	// Length of the current serial valid burst
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_run <= '0;
		end else if (serial_valid_i) begin
			valid_run <= valid_run + 1'b1;
		end else begin
			valid_run <= '0;
		end
	end

	valid_in_done: assert property (@(posedge clk) disable iff (reset)
		serial_valid_i |-> rlbp_done_i)
		else begin
			fail_count++;
			$error("serial valid seen outside the done phase");
		end

	count_in_period: assert property (@(posedge clk) disable iff (reset)
		start_i |-> count_i < period_i)
		else begin
			fail_count++;
			$error("frame count at or above the period");
		end

	valid_burst_len: assert property (@(posedge clk) disable iff (reset)
		$fell(serial_valid_i) |-> valid_run == rlbp_pkg::count_t'(rlbp_pkg::CODE_BITS))
		else begin
			fail_count++;
			$error("serial valid burst of %0d cycles", valid_run);
		end

endmodule

bind rlbp_readout_top rlbp_assert rlbp_assert_inst (
	.clk            (clk),
	.reset          (reset),
	.start_i        (start_i),
	.count_i        (count_o),
	.period_i       (period_i),
	.rlbp_done_i    (rlbp_done_o),
	.serial_valid_i (serial_valid_o)
);

// ==== rlbp_readout_top.sv ====
/*
 * RLBP pixel readout controller top level
 * Frame timer, capture sequencer, pattern window and serializer
 */
`timescale 1ns/1ps

module rlbp_readout_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              start_i,
	input  logic              pixel_i,
	input  rlbp_pkg::count_t  period_i,
	input  rlbp_pkg::count_t  vd_rise_i,
	input  rlbp_pkg::count_t  vd_fall_i,
	input  rlbp_pkg::count_t  sw_rise_i,
	input  rlbp_pkg::count_t  sw_fall_i,
	input  rlbp_pkg::count_t  sh_rise_i,
	input  rlbp_pkg::count_t  sh_fall_i,
	input  rlbp_pkg::count_t  sample_time_i,
	output rlbp_pkg::count_t  count_o,
	output logic              vd_o,
	output logic              sw_o,
	output logic              sh_o,
	output logic              rlbp_done_o,
	output logic              serial_o,
	output logic              serial_valid_o
);

	logic            pxl_done;
	logic            shift_en;
	rlbp_pkg::row_t  row_sel;
	logic            code_load;
	rlbp_pkg::code_t code;

	frame_timer frame_timer_inst (
		.clk           (clk),
		.reset         (reset),
		.start_i       (start_i),
		.period_i      (period_i),
		.vd_rise_i     (vd_rise_i),
		.vd_fall_i     (vd_fall_i),
		.sw_rise_i     (sw_rise_i),
		.sw_fall_i     (sw_fall_i),
		.sh_rise_i     (sh_rise_i),
		.sh_fall_i     (sh_fall_i),
		.sample_time_i (sample_time_i),
		.count_o       (count_o),
		.vd_o          (vd_o),
		.sw_o          (sw_o),
		.sh_o          (sh_o),
		.pxl_done_o    (pxl_done)
	);

	rlbp_sequencer rlbp_sequencer_inst (
		.clk         (clk),
		.reset       (reset),
		.start_i     (start_i),
		.pxl_done_i  (pxl_done),
		.shift_en_o  (shift_en),
		.row_sel_o   (row_sel),
		.code_load_o (code_load),
		.rlbp_done_o (rlbp_done_o)
	);

	window_shift window_shift_inst (
		.clk        (clk),
		.reset      (reset),
		.shift_en_i (shift_en),
		.row_sel_i  (row_sel),
		.pixel_i    (pixel_i),
		.code_o     (code)
	);

	code_serializer code_serializer_inst (
		.clk            (clk),
		.reset          (reset),
		.load_i         (code_load),
		.code_i         (code),
		.serial_o       (serial_o),
		.serial_valid_o (serial_valid_o)
	);

endmodule

// ==== code_serializer.sv ====
/*
 * Code serializer: loads the nine-bit pattern code and sends it
 * least significant bit first with a valid level
 */
`timescale 1ns/1ps

module code_serializer (
	input  logic             clk,
	input  logic             reset,
	input  logic             load_i,
	input  rlbp_pkg::code_t  code_i,
	output logic             serial_o,
	output logic             serial_valid_o
);

	localparam rlbp_pkg::sample_idx_t NUM_BITS =
		rlbp_pkg::sample_idx_t'(rlbp_pkg::CODE_BITS);

	rlbp_pkg::code_t       shift_q;
	rlbp_pkg::sample_idx_t bit_cnt_q;

	// Remaining bits, bit 0 already on the output after a load
	always_ff @(posedge clk) begin
		if (load_i) begin
			shift_q <= code_i >> 1;
		end else if (serial_valid_o) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			serial_o <= 1'b0;
			serial_valid_o <= 1'b0;
			bit_cnt_q <= '0;
		end else if (load_i) begin
			serial_o <= code_i[0];
			serial_valid_o <= 1'b1;
			bit_cnt_q <= rlbp_pkg::sample_idx_t'(1);
		end else if (serial_valid_o) begin
			if (bit_cnt_q == NUM_BITS) begin
				// Last bit has been on the line for its cycle
				serial_o <= 1'b0;
				serial_valid_o <= 1'b0;
				bit_cnt_q <= '0;
			end else begin
				serial_o <= shift_q[0];
				bit_cnt_q <= bit_cnt_q + 1'b1;
			end
		end
	end

endmodule

// ==== window_shift.sv ====
/*
 * Pattern window: demultiplexes the pixel bit onto one of three rows
 * and shifts it into that row's three-bit register
 */
`timescale 1ns/1ps

module window_shift (
	input  logic             clk,
	input  logic             reset,
	input  logic             shift_en_i,
	input  rlbp_pkg::row_t   row_sel_i,
	input  logic             pixel_i,
	output rlbp_pkg::code_t  code_o
);

	logic [rlbp_pkg::COLS-1:0] row_q [rlbp_pkg::ROWS];
	logic [rlbp_pkg::ROWS-1:0] row_en;

	// Row demultiplexer
	always_comb begin
		for (int r = 0; r < rlbp_pkg::ROWS; r++) begin
			row_en[r] = shift_en_i && (row_sel_i == rlbp_pkg::row_t'(r));
		end
	end

	// New bits enter at the top, so the first sample ends up in bit 0
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 0; r < rlbp_pkg::ROWS; r++) begin
				row_q[r] <= '0;
			end
		end else begin
			for (int r = 0; r < rlbp_pkg::ROWS; r++) begin
				if (row_en[r]) begin
					row_q[r] <= {pixel_i, row_q[r][rlbp_pkg::COLS-1:1]};
				end
			end
		end
	end

	// Row r fills code bits 3r to 3r+2
	always_comb begin
		for (int r = 0; r < rlbp_pkg::ROWS; r++) begin
			code_o[r*rlbp_pkg::COLS +: rlbp_pkg::COLS] = row_q[r];
		end
	end

endmodule

// ==== rlbp_sequencer.sv ====
/*
 * Capture sequencer: steps through nine pixel samples, selects the
 * window row for each, then holds the finished frame until start drops
 */
`timescale 1ns/1ps

module rlbp_sequencer (
	input  logic            clk,
	input  logic            reset,
	input  logic            start_i,
	input  logic            pxl_done_i,
	output logic            shift_en_o,
	output rlbp_pkg::row_t  row_sel_o,
	output logic            code_load_o,
	output logic            rlbp_done_o
);

	localparam rlbp_pkg::sample_idx_t LAST_IDX =
		rlbp_pkg::sample_idx_t'(rlbp_pkg::CODE_BITS - 1);

	rlbp_pkg::seq_state_t  state_q;
	rlbp_pkg::seq_state_t  state_d;
	rlbp_pkg::sample_idx_t idx_q;
	rlbp_pkg::sample_idx_t idx_d;
	logic                  code_load_q;

	always_comb begin
		state_d = state_q;
		idx_d = idx_q;
		case (state_q)
			rlbp_pkg::SEQ_IDLE: begin
				if (start_i) begin
					state_d = rlbp_pkg::SEQ_COLLECT;
					idx_d = '0;
				end
			end
			rlbp_pkg::SEQ_COLLECT: begin
				// Dropping start abandons the partial frame
				if (!start_i) begin
					state_d = rlbp_pkg::SEQ_IDLE;
				end else if (pxl_done_i) begin
					if (idx_q == LAST_IDX) begin
						state_d = rlbp_pkg::SEQ_HOLD;
					end else begin
						idx_d = idx_q + 1'b1;
					end
				end
			end
			rlbp_pkg::SEQ_HOLD: begin
				if (!start_i) begin
					state_d = rlbp_pkg::SEQ_IDLE;
				end
			end
			default: state_d = rlbp_pkg::SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= rlbp_pkg::SEQ_IDLE;
			idx_q <= '0;
			code_load_q <= 1'b0;
		end else begin
			state_q <= state_d;
			idx_q <= idx_d;
			// One pulse on entry to hold
			code_load_q <= (state_q == rlbp_pkg::SEQ_COLLECT) &&
				(state_d == rlbp_pkg::SEQ_HOLD);
		end
	end

	assign shift_en_o = (state_q == rlbp_pkg::SEQ_COLLECT) && pxl_done_i;
	assign row_sel_o = rlbp_pkg::row_t'(idx_q / rlbp_pkg::COLS);
	assign code_load_o = code_load_q;
	assign rlbp_done_o = (state_q == rlbp_pkg::SEQ_HOLD);

endmodule

// ==== frame_timer.sv ====
/*
 * Frame timer: wrapping period counter with decoded pixel control
 * windows (vertical drive, switch, sample-hold) and a sample strobe
 */
`timescale 1ns/1ps

module frame_timer (
	input  logic              clk,
	input  logic              reset,
	input  logic              start_i,
	input  rlbp_pkg::count_t  period_i,
	input  rlbp_pkg::count_t  vd_rise_i,
	input  rlbp_pkg::count_t  vd_fall_i,
	input  rlbp_pkg::count_t  sw_rise_i,
	input  rlbp_pkg::count_t  sw_fall_i,
	input  rlbp_pkg::count_t  sh_rise_i,
	input  rlbp_pkg::count_t  sh_fall_i,
	input  rlbp_pkg::count_t  sample_time_i,
	output rlbp_pkg::count_t  count_o,
	output logic              vd_o,
	output logic              sw_o,
	output logic              sh_o,
	output logic              pxl_done_o
);

	rlbp_pkg::count_t count_q;
	rlbp_pkg::count_t last_count;

	// Last count before the wrap
	assign last_count = rlbp_pkg::count_t'(period_i - 1'b1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count_q <= '0;
		end else if (!start_i) begin
			count_q <= '0;
		end else if (count_q >= last_count) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	assign count_o = count_q;

	// Half-open windows, high for rise <= count < fall
	always_comb begin
		vd_o = (count_q >= vd_rise_i) && (count_q < vd_fall_i);
		sw_o = (count_q >= sw_rise_i) && (count_q < sw_fall_i);
		sh_o = (count_q >= sh_rise_i) && (count_q < sh_fall_i);
	end

	// Comparator result ready once per period
	assign pxl_done_o = start_i && (count_q == sample_time_i);

endmodule

// ==== rlbp_pkg.sv ====
/*
 * RLBP readout shared definitions
 * Widths, vector types and the sequencer state encoding
 */
package rlbp_pkg;

	// Frame timer count and timing settings
	localparam int COUNT_W = 12;

	// Pattern window geometry
	localparam int ROWS = 3;
	localparam int COLS = 3;
	localparam int CODE_BITS = ROWS * COLS;

	// Index widths
	localparam int ROW_W = 2;
	localparam int IDX_W = 4;

	// Cycle counts and timing settings
	typedef logic [COUNT_W-1:0] count_t;

	// Pattern code, bit k is the k-th captured sample
	typedef logic [CODE_BITS-1:0] code_t;

	// Row index, 0 to ROWS-1
	typedef logic [ROW_W-1:0] row_t;

	// Sample index, 0 to 8 while capturing and 0 to 9 while serializing
	typedef logic [IDX_W-1:0] sample_idx_t;

	// Capture sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_COLLECT,
		SEQ_HOLD
	} seq_state_t;

endpackage
